/* tester_programs.hex */
// Each line holds 16 bytes. Per level: 2 lines of program (offsets 0..31),
// then 2 lines of expected dump bytes (indices 0..31). Levels 0, 1, 2 in order.
10 21 32 43 54 65 76 87 98 A9 BA CB DC ED FE 0F
1E 2D 3C 4B 5A 69 78 87 96 A5 B4 C3 D2 E1 F0 C0
00 11 22 33 44 55 66 77 88 99 AA BB CC DD EE FF
01 23 45 67 89 AB CD EF FE DC BA 98 76 54 32 10
A0 B1 C2 D3 E4 F5 06 17 28 39 4A 5B 6C 7D 8E 9F
3A 4B 5C 6D 7E 8F 90 A1 B2 C3 D4 E5 F6 07 18 C0
5A A5 3C C3 0F F0 69 96 12 34 56 78 9A BC DE F1
E7 7E D5 5D B3 3B 81 18 42 24 C6 6C A9 9A 17 71
F0 E1 D2 C3 B4 A5 96 87 78 69 5A 4B 3C 2D 1E 0F
47 58 69 7A 8B 9C AD BE CF D0 E1 F2 03 14 25 C0
13 57 9B DF 24 68 AC E0 35 79 BD F1 46 8A CE 02
8D 9E AF B0 C1 D2 E3 F4 05 16 27 38 49 5A 6B 7C

/* all.f */
tester_pkg.sv
program_server.sv
result_checker.sv
status_display.sv
cpu_tester.sv
tb_cpu_tester_sva.sv
tb_cpu_tester.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu_tester \
	-f all.f -o sim_tb \
	&& ./obj_dir/sim_tb | grep -F "=== PASS ===" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

/* tb_cpu_tester.sv */
`timescale 1ns/1ps

module tb_cpu_tester import tester_pkg::*;
();

	localparam int scroll_ticks = 3;
	localparam int clk_period = 8;
	localparam int scroll_cycles = 68;	// Covers all 16 offsets
	localparam int watchdog_cycles = level_count * (run_limit + dump_steps + 40);

	logic clk;
	logic areset;
	logic [level_w-1:0] level_sel;
	logic [word_w-1:0] imem_addr;
	logic [word_w-1:0] tb_data;
	logic [word_w-1:0] imem_data;
	logic green_light;
	logic orange_light;
	logic red_light;
	logic [seg_w-1:0] disp_0;
	logic [seg_w-1:0] disp_1;
	logic [seg_w-1:0] disp_2;
	logic [seg_w-1:0] disp_3;
	logic [seg_w-1:0] disp_4;
	logic [seg_w-1:0] disp_5;

	logic [word_w-1:0] tbl [table_depth];
	integer seed;
	int injected;

	// Model state, updated on every rising edge
	logic m_valid;
	logic m_cp;
	logic [level_w-1:0] m_lvl;
	int m_run;
	int m_step;
	int m_err;
	int m_tick;
	logic [3:0] m_off;
	logic [seg_w-1:0] m_disp [digit_count];

	cpu_tester #(.scroll_ticks(scroll_ticks)) uut (
		.clk(clk), .areset(areset), .level_sel(level_sel),
		.imem_addr(imem_addr), .tb_data(tb_data), .imem_data(imem_data),
		.green_light(green_light), .orange_light(orange_light), .red_light(red_light),
		.disp_0(disp_0), .disp_1(disp_1), .disp_2(disp_2),
		.disp_3(disp_3), .disp_4(disp_4), .disp_5(disp_5)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp)
		begin
			abort_run($sformatf("ERROR %s: got %h, expected %h", name, got, exp));
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	function automatic logic [seg_w-1:0] digit_seg(input int d);
		if (d >= 0 && d <= 9)
		begin
			return digit_glyphs[d];
		end
		return '0;
	endfunction

	function automatic logic [seg_w-1:0] message_glyph(input logic [level_w-1:0] lvl,
			input int err, input int idx);
		int tens;
		int units;
		logic [seg_w-1:0] g;
		tens = (err >= 30) ? 3 : (err >= 20) ? 2 : (err >= 10) ? 1 : 0;
		units = (err - 10 * tens) & 15;	// Four-bit digit arithmetic
		if (err == 0)
		begin
			g = pass_msg[idx];
			if (idx == pass_level_slot)
			begin
				g = digit_seg(int'(lvl));
			end
		end
		else
		begin
			g = fail_msg[idx];
			if (idx == fail_level_slot)
			begin
				g = digit_seg(int'(lvl));
			end
			else if (idx == fail_tens_slot)
			begin
				g = digit_seg(tens);
			end
			else if (idx == fail_units_slot)
			begin
				g = digit_seg(units);
			end
		end
		return g;
	endfunction

	// Fetch port value for the given phase, level, address and dump step
	function automatic logic [word_w-1:0] expected_fetch(input logic cp,
			input logic [level_w-1:0] lvl, input logic [word_w-1:0] addr, input int step);
		if (!cp)
		begin
			if (int'(addr) < prog_words)
			begin
				return tbl[int'(lvl) * 2 * prog_words + int'(addr)];
			end
			return halt_word;
		end
		if (step >= dump_steps)
		begin
			return halt_word;
		end
		if (step % 2 == 1)
		begin
			return (step == 1) ? dump_mem_first : dump_mem_rest;
		end
		return (step == 0) ? dump_arith_first : dump_arith_rest;
	endfunction

	always @(posedge clk)
	begin
		int mask;
		if (areset)
		begin
			m_valid = 1'b1;
			m_cp = 1'b0;
			m_lvl = (level_sel > 2'd2) ? 2'd2 : level_sel;
			m_run = 0;
			m_step = 0;
			m_err = 0;
			m_tick = 0;
			m_off = 4'd0;
			for (int i = 0; i < digit_count; i++)
			begin
				m_disp[i] = '0;
			end
		end
		else
		begin
			mask = m_cp ? 15 : 7;
			if (m_tick == scroll_ticks)
			begin
				m_tick = 0;
				for (int i = 0; i < digit_count; i++)
				begin
					m_disp[i] = message_glyph(m_lvl, m_err, (int'(m_off) + i) & mask);
				end
				m_off = 4'((int'(m_off) + 1) & mask);
			end
			else
			begin
				m_tick++;
			end
			if (m_cp && m_step < dump_steps)
			begin
				if (m_step % 2 == 1 &&
						tb_data != tbl[int'(m_lvl) * 2 * prog_words + prog_words + m_step / 2])
				begin
					m_err++;
				end
				m_step++;
			end
			if (!m_cp)
			begin
				if (tb_data == done_mark || m_run == run_limit)
				begin
					m_cp = 1'b1;
				end
				else
				begin
					m_run++;
				end
			end
		end
	end

	always @(negedge clk)
	begin
		if (m_valid)
		begin
			check_value("imem_data", 32'(imem_data), 32'(expected_fetch(m_cp, m_lvl,
				imem_addr, m_step)));
			check_value("orange_light", 32'(orange_light), 32'(!m_cp));
			check_value("red_light", 32'(red_light), 32'(m_err != 0));
			check_value("green_light", 32'(green_light), 32'(!(m_cp && m_err != 0)));
			check_value("disp_0", 32'(disp_0), 32'(m_disp[0]));
			check_value("disp_1", 32'(disp_1), 32'(m_disp[1]));
			check_value("disp_2", 32'(disp_2), 32'(m_disp[2]));
			check_value("disp_3", 32'(disp_3), 32'(m_disp[3]));
			check_value("disp_4", 32'(disp_4), 32'(m_disp[4]));
			check_value("disp_5", 32'(disp_5), 32'(m_disp[5]));
		end
	end

	task automatic run_level(input logic [level_w-1:0] sel, input logic use_done,
			input logic corrupt);
		int wait_cycles;
		level_sel = sel;
		areset = 1'b1;
		tb_data = 8'h00;
		injected = 0;
		repeat (2) next_cycle();
		areset = 1'b0;
		for (int a = 0; a <= 40; a++)
		begin
			imem_addr = 8'(a);	// Past the program end too
			next_cycle();
		end
		imem_addr = 8'h00;
		if (use_done)
		begin
			tb_data = done_mark;
			next_cycle();
			tb_data = 8'h00;
			check_value("orange_light", 32'(orange_light), 32'd0);
		end
		else
		begin
			wait_cycles = 41;
			while (orange_light)
			begin
				if (wait_cycles > run_limit + 1)
				begin
					abort_run("the run phase did not end at the cycle limit");
				end
				else
				begin
					next_cycle();
					wait_cycles++;
				end
			end
			check_value("run cycles", 32'(wait_cycles), 32'(run_limit + 1));
		end
		while (m_step < dump_steps)
		begin
			imem_addr = 8'($random(seed));
			if (m_step % 2 == 1)
			begin
				tb_data = tbl[int'(m_lvl) * 2 * prog_words + prog_words + m_step / 2];
				if (corrupt && ($random(seed) & 3) == 0)
				begin
					tb_data = tb_data ^ (8'($random(seed)) | 8'h01);
					injected++;
				end
			end
			else
			begin
				tb_data = 8'($random(seed));	// Not compared
			end
			next_cycle();
		end
		tb_data = 8'h00;
		check_value("red_light", 32'(red_light), 32'(injected != 0));
		check_value("green_light", 32'(green_light), 32'(injected == 0));
		repeat (scroll_cycles) next_cycle();
	endtask

	initial
	begin
		seed = 32'h0fb364b0;
		m_valid = 1'b0;
		areset = 1'b1;
		level_sel = '0;
		imem_addr = 8'h00;
		tb_data = 8'h00;
		$readmemh("tester_programs.hex", tbl);
		run_level(2'd0, 1'b1, 1'b0);
		run_level(2'd1, 1'b0, 1'b1);
		run_level(2'd3, 1'b1, 1'b1);	// Clamped to level 2
		$display("=== PASS ===");
		$finish;
	end

	initial
	begin
		#(watchdog_cycles * clk_period);
		abort_run("the watchdog expired before all levels finished");
	end

endmodule

/* tb_cpu_tester_sva.sv */
`timescale 1ns/1ps

module display_checks
(
	input logic clk,
	input logic areset,
	input logic check_phase,
	input logic orange_light,
	input logic red_light
);

	phase_holds: assert property (@(posedge clk) disable iff (areset)
		$past(check_phase) |-> check_phase)
		else $error("check_phase fell outside reset");

	// Errors are only counted once the dump has started
	red_after_run: assert property (@(posedge clk) disable iff (areset)
		red_light |-> !orange_light)
		else $error("red lamp lit during the run phase");

	red_holds: assert property (@(posedge clk) disable iff (areset)
		$past(red_light) |-> red_light)
		else $error("red lamp went off outside reset");

endmodule

bind status_display display_checks u_checks (
	.clk(clk), .areset(areset), .check_phase(check_phase),
	.orange_light(orange_light), .red_light(red_light)
);

/* cpu_tester.sv */
`timescale 1ns/1ps

module cpu_tester import tester_pkg::*;
#(
	parameter int scroll_ticks = 1 << 24
)
(
	input logic clk,
	input logic areset,
	input logic [level_w-1:0] level_sel,	// Sampled during reset
	input logic [word_w-1:0] imem_addr,
	input logic [word_w-1:0] tb_data,

	output logic [word_w-1:0] imem_data,
	output logic green_light,
	output logic orange_light,
	output logic red_light,
	output logic [seg_w-1:0] disp_0,
	output logic [seg_w-1:0] disp_1,
	output logic [seg_w-1:0] disp_2,
	output logic [seg_w-1:0] disp_3,
	output logic [seg_w-1:0] disp_4,
	output logic [seg_w-1:0] disp_5
);

	logic check_phase;
	logic [level_w-1:0] level;
	logic [word_w-1:0] expected;
	logic [word_w-1:0] dump_instr;
	logic [$clog2(prog_words)-1:0] dump_index;
	logic [word_w-1:0] err_count;

	program_server u_server (
		.clk(clk), .areset(areset), .level_sel(level_sel),
		.imem_addr(imem_addr), .tb_data(tb_data),
		.dump_instr(dump_instr), .dump_index(dump_index),
		.imem_data(imem_data), .check_phase(check_phase),
		.level(level), .expected(expected)
	);

	result_checker u_checker (
		.clk(clk), .areset(areset), .check_phase(check_phase),
		.tb_data(tb_data), .expected(expected),
		.dump_instr(dump_instr), .dump_index(dump_index), .err_count(err_count)
	);

	status_display #(.scroll_ticks(scroll_ticks)) u_display (
		.clk(clk), .areset(areset), .check_phase(check_phase),
		.level(level), .err_count(err_count),
		.green_light(green_light), .orange_light(orange_light), .red_light(red_light),
		.disp_0(disp_0), .disp_1(disp_1), .disp_2(disp_2),
		.disp_3(disp_3), .disp_4(disp_4), .disp_5(disp_5)
	);

endmodule

/* status_display.sv */
`timescale 1ns/1ps

module status_display import tester_pkg::*;
#(
	parameter int scroll_ticks = 1 << 24
)
(
	input logic clk,
	input logic areset,
	input logic check_phase,
	input logic [level_w-1:0] level,
	input logic [word_w-1:0] err_count,

	output logic green_light,
	output logic orange_light,
	output logic red_light,
	output logic [seg_w-1:0] disp_0,
	output logic [seg_w-1:0] disp_1,
	output logic [seg_w-1:0] disp_2,
	output logic [seg_w-1:0] disp_3,
	output logic [seg_w-1:0] disp_4,
	output logic [seg_w-1:0] disp_5
);

	logic [$clog2(scroll_ticks+1)-1:0] tick_cnt;
	logic [3:0] scroll_off;
	logic [3:0] wrap_mask;
	logic [3:0] err_tens;
	logic [3:0] err_units;
	logic [0:msg_len-1][seg_w-1:0] msg;
	logic [digit_count-1:0][seg_w-1:0] disp_q;

	function automatic logic [seg_w-1:0] seg_of(input logic [3:0] d);
		if (d <= 4'd9)
		begin
			seg_of = digit_glyphs[d];
		end
		else
		begin
			seg_of = '0;	// Blank
		end
	endfunction

	assign orange_light = ~check_phase;
	assign red_light = |err_count;
	assign green_light = ~(check_phase & red_light);

	assign err_tens = (err_count < 8'd10) ? 4'd0 :
			(err_count < 8'd20) ? 4'd1 :
			(err_count < 8'd30) ? 4'd2 : 4'd3;
	assign err_units = err_count[3:0] - err_tens * 4'd10;	// Mod 16 is enough

	always_comb
	begin
		if (err_count != '0)
		begin
			msg = fail_msg;
			msg[fail_level_slot] = seg_of(4'(level));
			msg[fail_tens_slot] = seg_of(err_tens);
			msg[fail_units_slot] = seg_of(err_units);
		end
		else
		begin
			msg = pass_msg;
			msg[pass_level_slot] = seg_of(4'(level));
		end
	end

	// Short message in run phase, full one after
	assign wrap_mask = check_phase ? 4'hF : 4'h7;

	always_ff @(posedge clk)
	begin
		if (areset)
		begin
			tick_cnt <= '0;
			scroll_off <= '0;
			disp_q <= '0;
		end
		else if (tick_cnt == $bits(tick_cnt)'(scroll_ticks))
		begin
			tick_cnt <= '0;
			scroll_off <= (scroll_off + 4'd1) & wrap_mask;
			for (int i = 0; i < digit_count; i++)
			begin
				disp_q[i] <= msg[(scroll_off + 4'(i)) & wrap_mask];
			end
		end
		else
		begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	assign disp_0 = disp_q[0];
	assign disp_1 = disp_q[1];
	assign disp_2 = disp_q[2];
	assign disp_3 = disp_q[3];
	assign disp_4 = disp_q[4];
	assign disp_5 = disp_q[5];

endmodule

/* result_checker.sv */
`timescale 1ns/1ps

module result_checker import tester_pkg::*;
(
	input logic clk,
	input logic areset,
	input logic check_phase,
	input logic [word_w-1:0] tb_data,
	input logic [word_w-1:0] expected,

	output logic [word_w-1:0] dump_instr,
	output logic [$clog2(prog_words)-1:0] dump_index,
	output logic [word_w-1:0] err_count
);

	logic [$clog2(dump_steps+1)-1:0] step;
	logic dump_done;
	logic first_pair;

	assign dump_done = (step == $bits(step)'(dump_steps));
	assign first_pair = (step < $bits(step)'(2));
	assign dump_index = step[$clog2(prog_words):1];	// One register per step pair

	always_comb
	begin
		if (dump_done)
		begin
			dump_instr = halt_word;
		end
		else if (step[0])
		begin
			dump_instr = first_pair ? dump_mem_first : dump_mem_rest;
		end
		else
		begin
			dump_instr = first_pair ? dump_arith_first : dump_arith_rest;
		end
	end

	always_ff @(posedge clk)
	begin
		if (areset)
		begin
			step <= '0;
			err_count <= '0;
		end
		else if (check_phase && !dump_done)
		begin
			step <= step + 1'b1;
			if (step[0] && tb_data != expected)
			begin
				err_count <= err_count + 1'b1;	// Dumped byte is on tb_data now
			end
		end
	end

endmodule

/* program_server.sv */
`timescale 1ns/1ps

module program_server import tester_pkg::*;
(
	input logic clk,
	input logic areset,
	input logic [level_w-1:0] level_sel,
	input logic [word_w-1:0] imem_addr,
	input logic [word_w-1:0] tb_data,
	input logic [word_w-1:0] dump_instr,
	input logic [$clog2(prog_words)-1:0] dump_index,

	output logic [word_w-1:0] imem_data,
	output logic check_phase,
	output logic [level_w-1:0] level,
	output logic [word_w-1:0] expected
);

	logic [word_w-1:0] prog_table [table_depth];
	logic [$clog2(run_limit+1)-1:0] run_cnt;
	logic [word_w-1:0] prog_word;
	logic [7:0] prog_idx;
	logic [7:0] exp_idx;

	// Each level owns 64 words: program first, expected bytes after
	initial
	begin
		$readmemh("tester_programs.hex", prog_table);
	end

	always_ff @(posedge clk)
	begin
		if (areset)
		begin
			check_phase <= 1'b0;
			run_cnt <= '0;
			if (level_sel > level_w'(level_count - 1))
			begin
				level <= level_w'(level_count - 1);	// Clamp to last level
			end
			else
			begin
				level <= level_sel;
			end
		end
		else if (!check_phase)
		begin
			if (tb_data == done_mark || run_cnt == $bits(run_cnt)'(run_limit))
			begin
				check_phase <= 1'b1;
			end
			else
			begin
				run_cnt <= run_cnt + 1'b1;
			end
		end
	end

	assign prog_idx = {level, 1'b0, imem_addr[$clog2(prog_words)-1:0]};
	assign exp_idx = {level, 1'b1, dump_index};

	assign prog_word = prog_table[prog_idx];
	assign expected = prog_table[exp_idx];

	always_comb
	begin
		if (check_phase)
		begin
			imem_data = dump_instr;
		end
		else if (imem_addr < word_w'(prog_words))
		begin
			imem_data = prog_word;
		end
		else
		begin
			imem_data = halt_word;	// Fetch past program end
		end
	end

endmodule

/* tester_pkg.sv */
package tester_pkg;

	localparam int word_w = 8;
	localparam int prog_words = 32;
	localparam int level_w = 2;
	localparam int level_count = 3;
	localparam int table_depth = 192;	// 3 levels of program + expected

	localparam logic [word_w-1:0] halt_word = 8'hC0;
	localparam logic [word_w-1:0] done_mark = 8'h22;
	localparam int run_limit = 100;
	localparam int dump_steps = 64;

	localparam logic [word_w-1:0] dump_arith_first = 8'hE0;
	localparam logic [word_w-1:0] dump_arith_rest = 8'hD1;
	localparam logic [word_w-1:0] dump_mem_first = 8'h50;
	localparam logic [word_w-1:0] dump_mem_rest = 8'h60;

	localparam int seg_w = 7;
	localparam int digit_count = 6;
	localparam int msg_len = 16;

	// Segment order is a..g from the top bit down
	localparam logic [0:9][seg_w-1:0] digit_glyphs = '{
		7'h7E, 7'h30, 7'h6D, 7'h79, 7'h33,
		7'h5B, 7'h5F, 7'h72, 7'h7F, 7'h7B
	};

	// Level digit goes into slot 6
	localparam logic [0:msg_len-1][seg_w-1:0] pass_msg = '{
		7'h0E, 7'h4F, 7'h1E, 7'h4F, 7'h0E, 7'h00, 7'h00, 7'h00,
		7'h67, 7'h77, 7'h5B, 7'h5B, 7'h4F, 7'h3D, 7'h08, 7'h00
	};

	// Level in slot 1, error count in slots 12 and 13
	localparam logic [0:msg_len-1][seg_w-1:0] fail_msg = '{
		7'h0E, 7'h00, 7'h00, 7'h47, 7'h77, 7'h06, 7'h0E, 7'h4F,
		7'h3D, 7'h08, 7'h08, 7'h4E, 7'h00, 7'h00, 7'h78, 7'h00
	};

	localparam int pass_level_slot = 6;
	localparam int fail_level_slot = 1;
	localparam int fail_tens_slot = 12;
	localparam int fail_units_slot = 13;

endpackage
